//--- list.f
hdl/ldst_pkg.sv
hdl/ldst_decode.sv
hdl/ldst_issue.sv
hdl/data_ram.sv
hdl/ldst_unit.sv
tb/ldst_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module ldst_unit_tb -f list.f -o ldst_sim

sim_out=$(./obj_dir/ldst_sim 2>&1) || true
echo "$sim_out"

grep -q "ALL TESTS PASSED" <<< "$sim_out"

//--- tb/ldst_unit_tb.sv
`timescale 1ns/1ps

module ldst_unit_tb;
	import ldst_pkg::*;

	localparam int MEM_BYTES = MEM_WORDS * 4;

	logic clock;
	logic rst;
	logic cmd_valid;
	logic cmd_ready;
	logic mode;
	logic [4:0] cmd;
	logic [DATA_W-1:0] source0;
	logic [DATA_W-1:0] source1;
	logic [DATA_W-1:0] adv_data;
	logic [DATA_W-1:0] pc;
	logic done;
	logic [DATA_W-1:0] result;
	logic [DATA_W-1:0] spr;

	// stimulus and expected values, one element per command
	logic t_mode [$];
	logic [4:0] t_cmd [$];
	logic [DATA_W-1:0] t_src0 [$];
	logic [DATA_W-1:0] t_src1 [$];
	logic [DATA_W-1:0] t_adv [$];
	logic [DATA_W-1:0] t_pc [$];
	logic [DATA_W-1:0] t_result [$];
	logic [DATA_W-1:0] t_spr [$];

	logic [7:0] model_mem [MEM_BYTES];	// byte view of the ram
	logic [DATA_W-1:0] model_spr;

	integer seed;
	int cycle_count;
	int cycle_limit = 1000000;

	ldst_unit UUT (
		.clock(clock),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.mode(mode),
		.cmd(cmd),
		.source0(source0),
		.source1(source1),
		.adv_data(adv_data),
		.pc(pc),
		.done(done),
		.result(result),
		.spr(spr)
	);

	initial
	begin
		clock = 1'b0;
	end

	always #5 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, the unit stopped completing commands",
				cycle_count);
			$display("SOME TESTS FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic int access_bytes(input logic [4:0] c);
		case (c)
			LD8, ST8, LDD8, STD8:
				return 1;
			LD16, ST16, LDD16, STD16:
				return 2;
			default:
				return 4;
		endcase
	endfunction

	// one access on the byte model, odd halfwords touch nothing
	task automatic model_access(input logic [DATA_W-1:0] ea, input int nbytes,
		input logic store, input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] loaded);
		logic [9:0] base;
		logic [9:0] idx;
		loaded = '0;
		base = ea[9:0];
		if (nbytes == 4)
		begin
			base[1:0] = 2'b00;
		end
		if (!(nbytes == 2 && base[0]))
		begin
			for (int k = 0; k < nbytes; k++)
			begin
				idx = base + 10'(k);
				if (store)
				begin
					model_mem[idx] = data[8*k +: 8];
				end
				else
				begin
					loaded[8*k +: 8] = model_mem[idx];
				end
			end
		end
	endtask

	task automatic model_step(input logic m, input logic [4:0] c,
		input logic [DATA_W-1:0] s0, input logic [DATA_W-1:0] s1,
		input logic [DATA_W-1:0] adv, input logic [DATA_W-1:0] p,
		output logic [DATA_W-1:0] exp_result);
		int nbytes;
		logic [DATA_W-1:0] ea;
		logic [DATA_W-1:0] loaded;
		exp_result = '0;
		nbytes = access_bytes(c);
		if (!m)
		begin
			if (c == READ_SPR)
			begin
				exp_result = model_spr;
			end
			else if (c == WRITE_SPR)
			begin
				model_spr = s0;
			end
			else
			begin
				model_spr = s0 + s1;	// any other code adds
			end
		end
		else
		begin
			case (c)
				LD8, LD16, LD32:
				begin
					model_access(s1, nbytes, 1'b0, '0, loaded);
					exp_result = loaded;
				end
				ST8, ST16, ST32:
				begin
					model_access(s1, nbytes, 1'b1, s0, loaded);
				end
				LDD8, LDD16, LDD32, STD8, STD16, STD32:
				begin
					ea = s1 + adv * nbytes;	// scaled displacement
					model_access(ea, nbytes, (c >= STD8), s0, loaded);
					if (c < STD8)
					begin
						exp_result = loaded;
					end
				end
				PUSH, PPUSH:
				begin
					model_spr = model_spr - 32'd4;
					model_access(model_spr, 4, 1'b1, (c == PPUSH) ? p : s0, loaded);
				end
				POP:
				begin
					model_access(model_spr, 4, 1'b0, '0, loaded);
					exp_result = loaded;
					model_spr = model_spr + 32'd4;
				end
				default:
				begin
					exp_result = '0;
				end
			endcase
		end
	endtask

	task automatic add_entry(input logic m, input logic [4:0] c,
		input logic [DATA_W-1:0] s0, input logic [DATA_W-1:0] s1,
		input logic [DATA_W-1:0] adv, input logic [DATA_W-1:0] p);
		logic [DATA_W-1:0] exp_result;
		model_step(m, c, s0, s1, adv, p, exp_result);
		t_mode.push_back(m);
		t_cmd.push_back(c);
		t_src0.push_back(s0);
		t_src1.push_back(s1);
		t_adv.push_back(adv);
		t_pc.push_back(p);
		t_result.push_back(exp_result);
		t_spr.push_back(model_spr);
	endtask

	task automatic build_table();
		logic [DATA_W-1:0] data;
		// words at 0x100..0x10c first, later loads read only stored bytes
		for (int w = 0; w < 4; w++)
		begin
			data = $random(seed);
			add_entry(1'b1, ST32, data, 32'h100 + 4 * w, '0, '0);
			add_entry(1'b1, LD32, '0, 32'h100 + 4 * w, '0, '0);
			add_entry(1'b1, LD16, '0, 32'h100 + 4 * w + 2 * (w % 2), '0, '0);
			add_entry(1'b1, LD8, '0, 32'h100 + 5 * w, '0, '0);	// byte lane w
		end
		for (int off = 0; off < 4; off++)
		begin
			data = $random(seed);
			add_entry(1'b1, ST8, data, 32'h100 + off, '0, '0);
			add_entry(1'b1, LD8, '0, 32'h100 + off, '0, '0);
			add_entry(1'b1, LD16, '0, 32'h100 + (off & 2), '0, '0);
			add_entry(1'b1, LD32, '0, 32'h100, '0, '0);
		end
		for (int off = 0; off < 4; off += 2)
		begin
			data = $random(seed);
			add_entry(1'b1, ST16, data, 32'h104 + off, '0, '0);
			add_entry(1'b1, LD16, '0, 32'h104 + off, '0, '0);
			add_entry(1'b1, LD8, '0, 32'h105 + off, '0, '0);
			add_entry(1'b1, LD32, '0, 32'h104, '0, '0);
		end
		// odd halfword offsets
		data = $random(seed);
		add_entry(1'b1, ST16, data, 32'h101, '0, '0);
		add_entry(1'b1, LD32, '0, 32'h100, '0, '0);
		add_entry(1'b1, LD16, '0, 32'h101, '0, '0);
		add_entry(1'b1, LD16, '0, 32'h103, '0, '0);
		add_entry(1'b1, LD8, '0, 32'h101, '0, '0);
		// displacement forms against plain accesses
		data = $random(seed);
		add_entry(1'b1, STD8, data, 32'h100, 32'd9, '0);
		add_entry(1'b1, LD8, '0, 32'h109, '0, '0);
		add_entry(1'b1, LDD8, '0, 32'h108, 32'd1, '0);
		add_entry(1'b1, LD32, '0, 32'h108, '0, '0);
		data = $random(seed);
		add_entry(1'b1, STD16, data, 32'h100, 32'd5, '0);
		add_entry(1'b1, LD16, '0, 32'h10a, '0, '0);
		add_entry(1'b1, LDD16, '0, 32'h104, 32'd3, '0);
		add_entry(1'b1, LDD16, '0, 32'h102, 32'd3, '0);
		data = $random(seed);
		add_entry(1'b1, STD32, data, 32'h104, 32'd2, '0);
		add_entry(1'b1, LD32, '0, 32'h10c, '0, '0);
		add_entry(1'b1, LDD32, '0, 32'h110, 32'hffff_ffff, '0);	// negative step
		add_entry(1'b1, LDD8, '0, 32'h10c, 32'd3, '0);
		// stack, three in and three out
		for (int k = 0; k < 3; k++)
		begin
			data = $random(seed);
			if (k == 1)
			begin
				add_entry(1'b1, PPUSH, ~data, '0, '0, data);
			end
			else
			begin
				add_entry(1'b1, PUSH, data, '0, '0, ~data);
			end
		end
		for (int k = 0; k < 3; k++)
		begin
			add_entry(1'b1, POP, '0, '0, '0, '0);
		end
		// system mode
		add_entry(1'b0, READ_SPR, '0, '0, '0, '0);
		add_entry(1'b0, WRITE_SPR, 32'h200, 32'h55, '0, '0);
		add_entry(1'b0, READ_SPR, '0, '0, '0, '0);
		add_entry(1'b0, ADD_SPR, 32'h180, 32'h80, '0, '0);
		add_entry(1'b0, 5'd9, 32'h300, 32'h100, '0, '0);	// unknown code adds
		add_entry(1'b0, READ_SPR, '0, '0, '0, '0);
		add_entry(1'b1, 5'd20, 32'h1234, 32'h100, '0, '0);	// undefined, no-op
		add_entry(1'b0, WRITE_SPR, 32'h200, '0, '0, '0);
		data = $random(seed);
		add_entry(1'b1, PUSH, data, '0, '0, '0);
		add_entry(1'b1, POP, '0, '0, '0, '0);
		add_entry(1'b0, READ_SPR, '0, '0, '0, '0);
	endtask

	task automatic apply_entry(input int i);
		int latency;
		@(negedge clock);
		while (!cmd_ready)
		begin
			@(negedge clock);
		end
		mode = t_mode[i];
		cmd = t_cmd[i];
		source0 = t_src0[i];
		source1 = t_src1[i];
		adv_data = t_adv[i];
		pc = t_pc[i];
		cmd_valid = 1'b1;
		@(negedge clock);	// accepted on the edge before
		cmd_valid = 1'b0;
		latency = 1;
		while (!done)
		begin
			@(negedge clock);
			latency++;
		end
		check_value("result", result, t_result[i]);
		check_value("spr", spr, t_spr[i]);
		if (!t_mode[i] || t_cmd[i] > STD32)
		begin
			check_value("done latency", latency, 32'd1);
		end
	endtask

	initial
	begin
		seed = 65;
		cycle_count = 0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		mode = 1'b0;
		cmd = '0;
		source0 = '0;
		source1 = '0;
		adv_data = '0;
		pc = '0;
		for (int a = 0; a < MEM_BYTES; a++)
		begin
			model_mem[10'(a)] = 8'h00;
		end
		model_spr = SPR_RESET;
		build_table();
		cycle_limit = 16 + 20 * t_cmd.size();

		repeat (16) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		check_value("spr", spr, SPR_RESET);
		check_value("done", {31'b0, done}, 32'd0);
		check_value("cmd_ready", {31'b0, cmd_ready}, 32'd1);

		for (int i = 0; i < t_cmd.size(); i++)
		begin
			apply_entry(i);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- hdl/ldst_unit.sv
`timescale 1ns/1ps

module ldst_unit (
	input logic clock,
	input logic rst,
	input logic cmd_valid,
	output logic cmd_ready,
	input logic mode,
	input logic [4:0] cmd,
	input logic [ldst_pkg::DATA_W-1:0] source0,
	input logic [ldst_pkg::DATA_W-1:0] source1,
	input logic [ldst_pkg::DATA_W-1:0] adv_data,
	input logic [ldst_pkg::DATA_W-1:0] pc,
	output logic done,
	output logic [ldst_pkg::DATA_W-1:0] result,
	output logic [ldst_pkg::DATA_W-1:0] spr
);
	import ldst_pkg::*;

	logic mem_en;
	logic rw;
	logic [DATA_W-1:0] dec_addr;
	logic [DATA_W-1:0] dec_wdata;
	logic [STRB_W-1:0] byte_mask;
	logic [1:0] load_shift;
	order_t order;
	logic spr_valid;
	logic [DATA_W-1:0] spr_next;
	logic [DATA_W-1:0] direct_data;

	// axi4-lite between issue stage and ram
	logic awvalid;
	logic awready;
	logic [DATA_W-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [DATA_W-1:0] axi_wdata;
	logic [STRB_W-1:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [DATA_W-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [DATA_W-1:0] rdata;
	logic [1:0] rresp;

	ldst_decode u_decode (
		.mode(mode),
		.cmd(cmd),
		.source0(source0),
		.source1(source1),
		.adv_data(adv_data),
		.pc(pc),
		.spr(spr),
		.mem_en(mem_en),
		.rw(rw),
		.addr(dec_addr),
		.wdata(dec_wdata),
		.byte_mask(byte_mask),
		.load_shift(load_shift),
		.order(order),
		.spr_valid(spr_valid),
		.spr_next(spr_next),
		.direct_data(direct_data)
	);

	ldst_issue u_issue (
		.clock(clock),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.mem_en(mem_en),
		.rw(rw),
		.addr(dec_addr),
		.wdata(dec_wdata),
		.byte_mask(byte_mask),
		.load_shift(load_shift),
		.order(order),
		.spr_valid(spr_valid),
		.spr_next(spr_next),
		.direct_data(direct_data),
		.done(done),
		.result(result),
		.spr(spr),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata_out(axi_wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp)
	);

	data_ram u_ram (
		.clock(clock),
		.rst(rst),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(axi_wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp)
	);

endmodule

//--- hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
	input logic clock,
	input logic rst,
	input logic awvalid,
	output logic awready,
	input logic [ldst_pkg::DATA_W-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [ldst_pkg::DATA_W-1:0] wdata,
	input logic [ldst_pkg::STRB_W-1:0] wstrb,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [ldst_pkg::DATA_W-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [ldst_pkg::DATA_W-1:0] rdata,
	output logic [1:0] rresp
);
	import ldst_pkg::*;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [MEM_AW-1:0] wr_idx;
	logic [MEM_AW-1:0] rd_idx;

	initial
	begin
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			mem[i] = '0;
		end
	end

	assign wr_idx = awaddr[MEM_AW+1:2];	// upper bits ignored
	assign rd_idx = araddr[MEM_AW+1:2];

	// aw and w taken together, one response outstanding
	assign awready = awvalid && wvalid && !bvalid;
	assign wready = awready;
	assign arready = !rvalid;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	always_ff @(posedge clock)
	begin
		if (awready)
		begin
			for (int b = 0; b < STRB_W; b++)
			begin
				if (wstrb[b])
				begin
					mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
		if (arvalid && arready)
		begin
			rdata <= mem[rd_idx];
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			if (awready)
			begin
				bvalid <= 1'b1;
			end
			else if (bready)
			begin
				bvalid <= 1'b0;
			end
			if (arvalid && arready)
			begin
				rvalid <= 1'b1;
			end
			else if (rready)
			begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

//--- hdl/ldst_issue.sv
`timescale 1ns/1ps

module ldst_issue (
	input logic clock,
	input logic rst,
	input logic cmd_valid,
	output logic cmd_ready,
	input logic mem_en,
	input logic rw,
	input logic [ldst_pkg::DATA_W-1:0] addr,
	input logic [ldst_pkg::DATA_W-1:0] wdata,
	input logic [ldst_pkg::STRB_W-1:0] byte_mask,
	input logic [1:0] load_shift,
	input ldst_pkg::order_t order,
	input logic spr_valid,
	input logic [ldst_pkg::DATA_W-1:0] spr_next,
	input logic [ldst_pkg::DATA_W-1:0] direct_data,
	output logic done,
	output logic [ldst_pkg::DATA_W-1:0] result,
	output logic [ldst_pkg::DATA_W-1:0] spr,
	output logic awvalid,
	input logic awready,
	output logic [ldst_pkg::DATA_W-1:0] awaddr,
	output logic wvalid,
	input logic wready,
	output logic [ldst_pkg::DATA_W-1:0] wdata_out,
	output logic [ldst_pkg::STRB_W-1:0] wstrb,
	input logic bvalid,
	output logic bready,
	input logic [1:0] bresp,
	output logic arvalid,
	input logic arready,
	output logic [ldst_pkg::DATA_W-1:0] araddr,
	input logic rvalid,
	output logic rready,
	input logic [ldst_pkg::DATA_W-1:0] rdata,
	input logic [1:0] rresp
);
	import ldst_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ,
		ST_FINISH
	} state_t;

	state_t state;

	logic accept;
	logic req_spr_valid;
	logic [DATA_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic [STRB_W-1:0] req_mask;
	logic [1:0] req_shift;
	order_t req_order;
	logic [DATA_W-1:0] req_spr_next;

	// keep masked lanes, shift down, zero-extend to access size
	function automatic logic [DATA_W-1:0] align_load(input logic [DATA_W-1:0] word,
		input logic [STRB_W-1:0] mask, input logic [1:0] shift, input order_t size);
		logic [DATA_W-1:0] lanes;
		logic [DATA_W-1:0] shifted;
		for (int i = 0; i < STRB_W; i++)
		begin
			lanes[8*i +: 8] = mask[i] ? word[8*i +: 8] : 8'h00;
		end
		shifted = lanes >> {shift, 3'b000};
		case (size)
			BYTE:
				return {{(DATA_W-8){1'b0}}, shifted[7:0]};
			HALF:
				return {{(DATA_W-16){1'b0}}, shifted[15:0]};
			default:
				return shifted;
		endcase
	endfunction

	assign cmd_ready = (state == ST_IDLE);
	assign accept = cmd_valid && cmd_ready;
	assign done = (state == ST_FINISH);

	assign awaddr = req_addr;
	assign araddr = req_addr;
	assign wdata_out = req_wdata;
	assign wstrb = req_mask;
	assign bready = 1'b1;	// responses never stalled
	assign rready = 1'b1;

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			req_addr <= addr;
			req_wdata <= wdata;
			req_mask <= byte_mask;	// strobes for stores, lane mask for loads
			req_shift <= load_shift;
			req_order <= order;
			req_spr_next <= spr_next;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			arvalid <= 1'b0;
			req_spr_valid <= 1'b0;
			result <= '0;
			spr <= SPR_RESET;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (accept)
					begin
						req_spr_valid <= spr_valid;
						if (!mem_en)
						begin
							state <= ST_FINISH;	// no bus access
							result <= direct_data;
							if (spr_valid)
							begin
								spr <= spr_next;
							end
						end
						else if (rw)
						begin
							state <= ST_WRITE;
							awvalid <= 1'b1;
							wvalid <= 1'b1;
						end
						else
						begin
							state <= ST_READ;
							arvalid <= 1'b1;
						end
					end
				end
				ST_WRITE:
				begin
					if (awready)
					begin
						awvalid <= 1'b0;
					end
					if (wready)
					begin
						wvalid <= 1'b0;
					end
					if (bvalid)
					begin
						state <= ST_FINISH;
						result <= '0;
						if (req_spr_valid && bresp == RESP_OKAY)
						begin
							spr <= req_spr_next;	// push moves sp only on success
						end
					end
				end
				ST_READ:
				begin
					if (arready)
					begin
						arvalid <= 1'b0;
					end
					if (rvalid)
					begin
						state <= ST_FINISH;
						result <= (rresp == RESP_OKAY) ?
							align_load(rdata, req_mask, req_shift, req_order) : '0;
						if (req_spr_valid && rresp == RESP_OKAY)
						begin
							spr <= req_spr_next;
						end
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/ldst_decode.sv
`timescale 1ns/1ps

module ldst_decode (
	input logic mode,	// 1 ldst, 0 system
	input logic [4:0] cmd,
	input logic [ldst_pkg::DATA_W-1:0] source0,
	input logic [ldst_pkg::DATA_W-1:0] source1,
	input logic [ldst_pkg::DATA_W-1:0] adv_data,
	input logic [ldst_pkg::DATA_W-1:0] pc,
	input logic [ldst_pkg::DATA_W-1:0] spr,
	output logic mem_en,
	output logic rw,	// 1 store
	output logic [ldst_pkg::DATA_W-1:0] addr,
	output logic [ldst_pkg::DATA_W-1:0] wdata,
	output logic [ldst_pkg::STRB_W-1:0] byte_mask,
	output logic [1:0] load_shift,
	output ldst_pkg::order_t order,
	output logic spr_valid,
	output logic [ldst_pkg::DATA_W-1:0] spr_next,
	output logic [ldst_pkg::DATA_W-1:0] direct_data
);
	import ldst_pkg::*;

	logic [DATA_W-1:0] store_src;

	function automatic logic [STRB_W-1:0] lane_mask(input order_t size, input logic [1:0] off);
		case (size)
			BYTE:
				return 4'b0001 << off;
			HALF:
				return (off == 2'h0) ? 4'b0011 : (off == 2'h2) ? 4'b1100 : 4'b0000;
			WORD:
				return 4'b1111;
			default:
				return 4'b0000;
		endcase
	endfunction

	function automatic logic [1:0] lane_shift(input order_t size, input logic [1:0] off);
		case (size)
			BYTE:
				return off;
			HALF:
				return (off == 2'h0) ? 2'h0 : 2'h2;
			default:
				return 2'h0;
		endcase
	endfunction

	// moves store data into its lanes, other lanes zero
	function automatic logic [DATA_W-1:0] place_data(input order_t size, input logic [1:0] off,
		input logic [DATA_W-1:0] data);
		case (size)
			BYTE:
				return {{(DATA_W-8){1'b0}}, data[7:0]} << {off, 3'b000};
			HALF:
				if (off == 2'h0)
				begin
					return {16'h0, data[15:0]};
				end
				else if (off == 2'h2)
				begin
					return {data[15:0], 16'h0};
				end
				else
				begin
					return '0;	// misaligned, nothing written
				end
			default:
				return data;
		endcase
	endfunction

	always_comb
	begin
		mem_en = 1'b0;
		rw = 1'b0;
		addr = source1;
		order = WORD;
		store_src = source0;
		spr_valid = 1'b0;
		spr_next = spr;
		direct_data = '0;
		if (mode)
		begin
			case (ldst_cmd_t'(cmd))
				LD8, LD16, LD32:
				begin
					mem_en = 1'b1;
					order = (cmd == LD8) ? BYTE : (cmd == LD16) ? HALF : WORD;
				end
				ST8, ST16, ST32:
				begin
					mem_en = 1'b1;
					rw = 1'b1;
					order = (cmd == ST8) ? BYTE : (cmd == ST16) ? HALF : WORD;
				end
				PUSH, PPUSH:
				begin
					mem_en = 1'b1;
					rw = 1'b1;
					addr = spr - 32'h4;	// pre-decrement
					store_src = (cmd == PPUSH) ? pc : source0;
					spr_valid = 1'b1;
					spr_next = spr - 32'h4;
				end
				POP:
				begin
					mem_en = 1'b1;
					addr = spr;
					spr_valid = 1'b1;
					spr_next = spr + 32'h4;
				end
				LDD8, STD8:
				begin
					mem_en = 1'b1;
					rw = (cmd == STD8);
					addr = source1 + adv_data;
					order = BYTE;
				end
				LDD16, STD16:
				begin
					mem_en = 1'b1;
					rw = (cmd == STD16);
					addr = source1 + {adv_data[DATA_W-2:0], 1'b0};	// scaled by 2
					order = HALF;
				end
				LDD32, STD32:
				begin
					mem_en = 1'b1;
					rw = (cmd == STD32);
					addr = source1 + {adv_data[DATA_W-3:0], 2'b00};
				end
				default:
				begin
					mem_en = 1'b0;	// undefined, completes as a no-op
				end
			endcase
		end
		else
		begin
			spr_valid = 1'b1;
			case (sys_cmd_t'(cmd))
				READ_SPR:
				begin
					direct_data = spr;
				end
				WRITE_SPR:
				begin
					spr_next = source0;
				end
				default:
				begin
					spr_next = source0 + source1;
				end
			endcase
		end
	end

	assign byte_mask = mem_en ? lane_mask(order, addr[1:0]) : '0;
	assign load_shift = lane_shift(order, addr[1:0]);
	assign wdata = (mem_en && rw) ? place_data(order, addr[1:0], store_src) : '0;

endmodule

//--- hdl/ldst_pkg.sv
package ldst_pkg;

	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;	// byte lanes per word
	localparam logic [DATA_W-1:0] SPR_RESET = 32'h0000_0400;

	localparam int MEM_WORDS = 256;
	localparam int MEM_AW = $clog2(MEM_WORDS);	// word index bits, addr[9:2]

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// normal mode commands
	typedef enum logic [4:0] {
		LD8,
		LD16,
		LD32,
		ST8,
		ST16,
		ST32,
		PUSH,
		PPUSH,
		POP,
		LDD8,
		LDD16,
		LDD32,
		STD8,
		STD16,
		STD32
	} ldst_cmd_t;

	// system mode, unknown codes act as add
	typedef enum logic [4:0] {
		READ_SPR,
		WRITE_SPR,
		ADD_SPR
	} sys_cmd_t;

	typedef enum logic [1:0] {
		BYTE,
		HALF,
		WORD
	} order_t;

endpackage
